//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_core_pkg.sv
      - hw/mem_port_if.sv
      - hw/core_ctrl.sv
      - hw/fetch_stage.sv
      - hw/decode_stage.sv
      - hw/execute_stage.sv
      - hw/memory_stage.sv
      - hw/rv_core.sv
  - target: test
    files:
      - tb/tb_mem_model.sv
      - tb/tb_rv_core.sv

//--- rv_core.f
+incdir+hw
hw/rv_core_pkg.sv
hw/mem_port_if.sv
hw/core_ctrl.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/rv_core.sv
tb/tb_mem_model.sv
tb/tb_rv_core.sv

//--- tb/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core
	import rv_core_pkg::*;
();

	localparam logic [6:0] OPC_IMM  = 7'b0010011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [2:0] F_ADD    = 3'b000;
	localparam logic [2:0] F_SLT    = 3'b010;
	localparam logic [2:0] F_XOR    = 3'b100;
	localparam logic [2:0] F_OR     = 3'b110;
	localparam logic [2:0] F_AND    = 3'b111;
	localparam logic [2:0] F_BEQ    = 3'b000;
	localparam logic [2:0] F_BNE    = 3'b001;
	localparam logic [2:0] F_WORD   = 3'b010;

	logic   clk;
	logic   arst_n;
	logic   imem_req;
	addr_t  imem_addr;
	logic   imem_ready;
	word_t  imem_rdata;
	logic   imem_rvalid;
	logic   dmem_req;
	addr_t  dmem_addr;
	logic   dmem_write;
	word_t  dmem_wdata;
	wmask_t dmem_wmask;
	logic   dmem_ready;
	word_t  dmem_rdata;
	logic   dmem_rvalid;

	word_t  prog [$];
	addr_t  exp_addr [$];
	word_t  exp_data [$];
	int     row;
	int     cycles;
	int     cycle_limit;
	logic   fetch_seen;

	rv_core dut0 (
		.clk(clk), .arst_n(arst_n),
		.imem_req(imem_req), .imem_addr(imem_addr),
		.imem_ready(imem_ready), .imem_rdata(imem_rdata), .imem_rvalid(imem_rvalid),
		.dmem_req(dmem_req), .dmem_addr(dmem_addr), .dmem_write(dmem_write),
		.dmem_wdata(dmem_wdata), .dmem_wmask(dmem_wmask),
		.dmem_ready(dmem_ready), .dmem_rdata(dmem_rdata), .dmem_rvalid(dmem_rvalid)
	);

	tb_mem_model mem0 (
		.clk(clk), .arst_n(arst_n),
		.imem_req(imem_req), .imem_addr(imem_addr),
		.imem_ready(imem_ready), .imem_rdata(imem_rdata), .imem_rvalid(imem_rvalid),
		.dmem_req(dmem_req), .dmem_addr(dmem_addr), .dmem_write(dmem_write),
		.dmem_wdata(dmem_wdata), .dmem_wmask(dmem_wmask),
		.dmem_ready(dmem_ready), .dmem_rdata(dmem_rdata), .dmem_rvalid(dmem_rvalid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ********************************************************
	// Instruction encoders
	// ********************************************************
	function automatic word_t r_type(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
		reg_idx_t rs2, logic sub);
		return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t i_type(logic [6:0] opc, logic [2:0] f3, reg_idx_t rd,
		reg_idx_t rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t s_type(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] off);
		return {off[11:5], rs2, rs1, F_WORD, off[4:0], 7'b0100011};
	endfunction

	function automatic word_t b_type(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
		logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic word_t j_type(reg_idx_t rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	function automatic word_t u_type(reg_idx_t rd, logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction

	task automatic build_program();
		// x1 base 0x40, x2 = 100, x3 = -7
		prog.push_back(i_type(OPC_IMM, F_ADD, 5'd1, 5'd0, 12'h040));
		prog.push_back(i_type(OPC_IMM, F_ADD, 5'd2, 5'd0, 12'd100));
		prog.push_back(i_type(OPC_IMM, F_ADD, 5'd3, 5'd0, 12'hff9));
		prog.push_back(r_type(F_ADD, 5'd4, 5'd2, 5'd3, 1'b0));
		prog.push_back(s_type(5'd4, 5'd1, 12'd0));
		prog.push_back(r_type(F_ADD, 5'd5, 5'd3, 5'd2, 1'b1));
		prog.push_back(s_type(5'd5, 5'd1, 12'd4));
		prog.push_back(r_type(F_AND, 5'd6, 5'd2, 5'd3, 1'b0));
		prog.push_back(s_type(5'd6, 5'd1, 12'd8));
		prog.push_back(r_type(F_OR, 5'd7, 5'd2, 5'd3, 1'b0));
		prog.push_back(s_type(5'd7, 5'd1, 12'd12));
		prog.push_back(r_type(F_XOR, 5'd8, 5'd2, 5'd3, 1'b0));
		prog.push_back(s_type(5'd8, 5'd1, 12'd16));
		prog.push_back(r_type(F_SLT, 5'd9, 5'd3, 5'd2, 1'b0));
		prog.push_back(s_type(5'd9, 5'd1, 12'd20));
		prog.push_back(r_type(F_SLT, 5'd10, 5'd2, 5'd3, 1'b0));
		prog.push_back(s_type(5'd10, 5'd1, 12'd24));
		// Immediate forms and LUI
		prog.push_back(i_type(OPC_IMM, F_AND, 5'd11, 5'd2, 12'h0f0));
		prog.push_back(i_type(OPC_IMM, F_OR, 5'd12, 5'd2, 12'hf00));
		prog.push_back(i_type(OPC_IMM, F_XOR, 5'd13, 5'd3, 12'h123));
		prog.push_back(u_type(5'd14, 20'h12345));
		prog.push_back(s_type(5'd11, 5'd1, 12'd28));
		prog.push_back(s_type(5'd12, 5'd1, 12'd32));
		prog.push_back(s_type(5'd13, 5'd1, 12'd36));
		prog.push_back(s_type(5'd14, 5'd1, 12'd40));
		// Back to back dependent chain
		prog.push_back(i_type(OPC_IMM, F_ADD, 5'd15, 5'd14, 12'h678));
		prog.push_back(i_type(OPC_IMM, F_ADD, 5'd15, 5'd15, 12'd1));
		prog.push_back(r_type(F_XOR, 5'd15, 5'd15, 5'd2, 1'b0));
		prog.push_back(s_type(5'd15, 5'd1, 12'd44));
		// Load then immediate use
		prog.push_back(i_type(OPC_LOAD, F_WORD, 5'd16, 5'd1, 12'd0));
		prog.push_back(i_type(OPC_IMM, F_ADD, 5'd16, 5'd16, 12'd7));
		prog.push_back(s_type(5'd16, 5'd1, 12'd48));
		prog.push_back(i_type(OPC_LOAD, F_WORD, 5'd17, 5'd1, 12'd40));
		prog.push_back(s_type(5'd17, 5'd1, 12'd52));
		// Wrong branch outcomes show up as stray or missing stores
		prog.push_back(b_type(F_BEQ, 5'd2, 5'd3, 13'd8));
		prog.push_back(i_type(OPC_IMM, F_ADD, 5'd18, 5'd0, 12'h011));
		prog.push_back(b_type(F_BNE, 5'd2, 5'd3, 13'd12));
		prog.push_back(s_type(5'd2, 5'd1, 12'd56));
		prog.push_back(s_type(5'd3, 5'd1, 12'd56));
		prog.push_back(s_type(5'd18, 5'd1, 12'd56));
		prog.push_back(b_type(F_BEQ, 5'd2, 5'd2, 13'd8));
		prog.push_back(s_type(5'd3, 5'd1, 12'd60));
		prog.push_back(b_type(F_BNE, 5'd2, 5'd2, 13'd8));
		prog.push_back(j_type(5'd19, 21'd12));
		prog.push_back(s_type(5'd2, 5'd1, 12'd60));
		prog.push_back(s_type(5'd2, 5'd1, 12'd60));
		prog.push_back(s_type(5'd19, 5'd1, 12'd60));
		// Park in a self loop
		prog.push_back(j_type(5'd0, 21'd0));
	endtask

	task automatic add_row(addr_t a, word_t d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	task automatic fill_table();
		add_row(32'h0000_0040, 32'h0000_005d);
		add_row(32'h0000_0044, 32'hffff_ff95);
		add_row(32'h0000_0048, 32'h0000_0060);
		add_row(32'h0000_004c, 32'hffff_fffd);
		add_row(32'h0000_0050, 32'hffff_ff9d);
		add_row(32'h0000_0054, 32'h0000_0001);
		add_row(32'h0000_0058, 32'h0000_0000);
		add_row(32'h0000_005c, 32'h0000_0060);
		add_row(32'h0000_0060, 32'hffff_ff64);
		add_row(32'h0000_0064, 32'hffff_feda);
		add_row(32'h0000_0068, 32'h1234_5000);
		// 0x12345678 + 1, then xor 100
		add_row(32'h0000_006c, 32'h1234_561d);
		add_row(32'h0000_0070, 32'h0000_0064);
		add_row(32'h0000_0074, 32'h1234_5000);
		add_row(32'h0000_0078, 32'h0000_0011);
		// JAL link at 0xac
		add_row(32'h0000_007c, 32'h0000_00b0);
	endtask

	// ********************************************************
	// Checks
	// ********************************************************
	task automatic stop_on_failure();
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_flag(string name, logic expected, logic actual);
		if (expected !== actual) begin
			$display("Error: %s expected %h actual %h (after %0d stores)",
				name, expected, actual, row);
			stop_on_failure();
		end
	endtask

	task automatic check_addr(string name, addr_t expected, addr_t actual);
		if (expected !== actual) begin
			$display("Error: %s expected %h actual %h (after %0d stores)",
				name, expected, actual, row);
			stop_on_failure();
		end
	endtask

	task automatic check_word(string name, word_t expected, word_t actual);
		if (expected !== actual) begin
			$display("Error: %s expected %h actual %h (after %0d stores)",
				name, expected, actual, row);
			stop_on_failure();
		end
	endtask

	task automatic check_mask(string name, wmask_t expected, wmask_t actual);
		if (expected !== actual) begin
			$display("Error: %s expected %h actual %h (after %0d stores)",
				name, expected, actual, row);
			stop_on_failure();
		end
	endtask

	// Both ports stay quiet in reset
	always @(negedge clk) begin
		if (!arst_n) begin
			check_flag("imem_req", 1'b0, imem_req);
			check_flag("dmem_req", 1'b0, dmem_req);
		end else if (!fetch_seen && imem_req && imem_ready) begin
			// First fetch comes from the reset PC
			check_addr("imem_addr", 32'h0000_0000, imem_addr);
			fetch_seen = 1'b1;
		end
	end

	// Accepted stores, sampled mid cycle
	always @(negedge clk) begin
		if (arst_n && dmem_req && dmem_ready && dmem_write) begin
			if (row >= exp_addr.size()) begin
				$display("A store to %h came after the last expected store", dmem_addr);
				stop_on_failure();
			end else begin
				check_addr("dmem_addr", exp_addr[row], dmem_addr);
				check_word("dmem_wdata", exp_data[row], dmem_wdata);
				check_mask("dmem_wmask", 4'hf, dmem_wmask);
				row = row + 1;
			end
		end
	end

	always @(posedge clk) begin
		if (arst_n) begin
			cycles <= cycles + 1;
			if (cycles >= cycle_limit) begin
				$display("Timeout: only %0d of %0d stores seen in %0d cycles",
					row, exp_addr.size(), cycles);
				stop_on_failure();
			end
		end
	end

	initial begin
		arst_n     = 1'b0;
		row        = 0;
		cycles     = 0;
		fetch_seen = 1'b0;
		fill_table();
		cycle_limit = exp_addr.size() * 200;
		build_program();
		@(posedge clk);
		for (int k = 0; k < prog.size(); k++)
			mem0.imem_words[k] = prog[k];
		repeat (7) @(posedge clk);
		arst_n <= 1'b1;
		while (row < exp_addr.size())
			@(posedge clk);
		// Drain window to catch late or repeated stores
		repeat (20) @(posedge clk);
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- tb/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model
	import rv_core_pkg::*;
#(
	parameter int WORDS = 64
) (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   imem_req,
	input  addr_t  imem_addr,
	output logic   imem_ready,
	output word_t  imem_rdata,
	output logic   imem_rvalid,
	input  logic   dmem_req,
	input  addr_t  dmem_addr,
	input  logic   dmem_write,
	input  word_t  dmem_wdata,
	input  wmask_t dmem_wmask,
	output logic   dmem_ready,
	output word_t  dmem_rdata,
	output logic   dmem_rvalid
);

	localparam int IDX_W = $clog2(WORDS);

	word_t  imem_words [WORDS];
	word_t  dmem_words [WORDS];
	integer seed;
	logic   i_busy;
	logic   d_busy;
	int     i_wait;
	int     d_wait;
	word_t  i_data;
	word_t  d_data;
	int     lat;

	initial begin
		seed        = 32'hb5a8;
		imem_ready  = 1'b0;
		imem_rdata  = '0;
		imem_rvalid = 1'b0;
		dmem_ready  = 1'b0;
		dmem_rdata  = '0;
		dmem_rvalid = 1'b0;
		i_busy      = 1'b0;
		d_busy      = 1'b0;
		i_wait      = 0;
		d_wait      = 0;
		for (int a = 0; a < WORDS; a++) begin
			// Unused fetch slots hold addi x0, x0, index
			imem_words[a] = {12'(a), 5'd0, 3'd0, 5'd0, 7'b0010011};
			dmem_words[a] = 32'h5a00_0000 | word_t'(a << 2);
		end
	end

	// ********************************************************
	// Responders for both ports
	// ********************************************************
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			imem_ready  <= 1'b0;
			imem_rvalid <= 1'b0;
			i_busy      <= 1'b0;
			i_wait      <= 0;
			dmem_ready  <= 1'b0;
			dmem_rvalid <= 1'b0;
			d_busy      <= 1'b0;
			d_wait      <= 0;
		end else begin
			// Ready about three cycles in four
			imem_ready  <= ($random(seed) & 3) != 0;
			dmem_ready  <= ($random(seed) & 3) != 0;
			imem_rvalid <= 1'b0;
			dmem_rvalid <= 1'b0;

			if (i_busy) begin
				if (i_wait == 0) begin
					imem_rvalid <= 1'b1;
					imem_rdata  <= i_data;
					i_busy      <= 1'b0;
				end else begin
					i_wait <= i_wait - 1;
				end
			end else if (imem_req && imem_ready) begin
				lat = $unsigned($random(seed)) % 4;
				i_data <= imem_words[imem_addr[2 +: IDX_W]];
				i_busy <= 1'b1;
				i_wait <= lat;
			end

			if (d_busy) begin
				if (d_wait == 0) begin
					dmem_rvalid <= 1'b1;
					dmem_rdata  <= d_data;
					d_busy      <= 1'b0;
				end else begin
					d_wait <= d_wait - 1;
				end
			end else if (dmem_req && dmem_ready) begin
				if (dmem_write) begin
					for (int b = 0; b < 4; b++)
						if (dmem_wmask[b])
							dmem_words[dmem_addr[2 +: IDX_W]][8*b +: 8] <= dmem_wdata[8*b +: 8];
				end else begin
					lat = $unsigned($random(seed)) % 4;
					d_data <= dmem_words[dmem_addr[2 +: IDX_W]];
					d_busy <= 1'b1;
					d_wait <= lat;
				end
			end
		end
	end

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ps

module rv_core
	import rv_core_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	output logic   imem_req,
	output addr_t  imem_addr,
	input  logic   imem_ready,
	input  word_t  imem_rdata,
	input  logic   imem_rvalid,
	output logic   dmem_req,
	output addr_t  dmem_addr,
	output logic   dmem_write,
	output word_t  dmem_wdata,
	output wmask_t dmem_wmask,
	input  logic   dmem_ready,
	input  word_t  dmem_rdata,
	input  logic   dmem_rvalid
);

	fd_bundle_t fd;
	de_bundle_t de;
	em_bundle_t em;
	logic       stall_f;
	logic       stall_d;
	logic       bubble_e;
	logic       flush_fd;
	logic       stall_m;
	logic       redirect;
	addr_t      redirect_pc;
	logic       wb_en;
	reg_idx_t   wb_rd;
	word_t      wb_data;
	logic       d_valid;
	reg_idx_t   d_rs1;
	reg_idx_t   d_rs2;
	logic       d_uses_rs2;
	logic       e_valid;
	reg_idx_t   e_rd;
	logic       m_valid;
	reg_idx_t   m_rd;
	logic       m_busy;

	mem_port_if imem_if ();
	mem_port_if dmem_if ();

	// ********************************************************
	// Memory ports
	// ********************************************************
	assign imem_req       = imem_if.req;
	assign imem_addr      = imem_if.addr;
	assign imem_if.ready  = imem_ready;
	assign imem_if.rdata  = imem_rdata;
	assign imem_if.rvalid = imem_rvalid;

	assign dmem_req       = dmem_if.req;
	assign dmem_addr      = dmem_if.addr;
	assign dmem_write     = dmem_if.write;
	assign dmem_wdata     = dmem_if.wdata;
	assign dmem_wmask     = dmem_if.wmask;
	assign dmem_if.ready  = dmem_ready;
	assign dmem_if.rdata  = dmem_rdata;
	assign dmem_if.rvalid = dmem_rvalid;

	// ********************************************************
	// Control and stages
	// ********************************************************
	core_ctrl ctrl0 (
		.clk(clk), .arst_n(arst_n),
		.d_valid(d_valid), .d_rs1(d_rs1), .d_rs2(d_rs2), .d_uses_rs2(d_uses_rs2),
		.e_valid(e_valid), .e_rd(e_rd),
		.m_valid(m_valid), .m_rd(m_rd), .m_busy(m_busy),
		.redirect(redirect),
		.stall_f(stall_f), .stall_d(stall_d), .bubble_e(bubble_e),
		.flush_fd(flush_fd), .stall_m(stall_m)
	);

	fetch_stage fetch0 (
		.clk(clk), .arst_n(arst_n),
		.stall_f(stall_f), .flush_fd(flush_fd),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.imem(imem_if.requester),
		.fd(fd)
	);

	decode_stage decode0 (
		.clk(clk), .arst_n(arst_n),
		.stall_d(stall_d), .flush_fd(flush_fd), .bubble_e(bubble_e),
		.fd(fd),
		.wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
		.de(de),
		.d_valid(d_valid), .d_rs1(d_rs1), .d_rs2(d_rs2), .d_uses_rs2(d_uses_rs2)
	);

	execute_stage execute0 (
		.clk(clk), .arst_n(arst_n),
		.stall_m(stall_m),
		.de(de),
		.em(em),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.e_valid(e_valid), .e_rd(e_rd)
	);

	memory_stage memory0 (
		.clk(clk), .arst_n(arst_n),
		.em(em),
		.dmem(dmem_if.requester),
		.wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
		.m_valid(m_valid), .m_rd(m_rd), .m_busy(m_busy)
	);

endmodule

//--- hw/memory_stage.sv
`timescale 1ns/1ps

module memory_stage
	import rv_core_pkg::*;
(
	input  logic          clk,
	input  logic          arst_n,
	input  em_bundle_t    em,
	mem_port_if.requester dmem,
	output logic          wb_en,
	output reg_idx_t      wb_rd,
	output word_t         wb_data,
	output logic          m_valid,
	output reg_idx_t      m_rd,
	output logic          m_busy
);

	typedef enum logic [1:0] {IDLE, REQ, WAIT} mem_state_e;

	mem_state_e state_q;
	logic       mem_op;
	logic       done;

	assign mem_op = em.valid && (em.mem_read || em.mem_write);

	// em is frozen while busy, so the request fields stay put
	assign dmem.req   = mem_op && (state_q != WAIT);
	assign dmem.addr  = addr_t'(em.alu_result);
	assign dmem.write = em.mem_write;
	assign dmem.wdata = em.store_data;
	assign dmem.wmask = em.mem_write ? 4'hf : 4'h0;

	// Store ends on acceptance, load on rvalid
	assign done = (dmem.req && dmem.ready && em.mem_write) ||
		(state_q == WAIT && dmem.rvalid);
	assign m_busy = mem_op && !done;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= IDLE;
		end else begin
			case (state_q)
				IDLE, REQ: begin
					if (dmem.req && dmem.ready)
						state_q <= em.mem_read ? WAIT : IDLE;
					else if (dmem.req)
						state_q <= REQ;
				end
				WAIT: begin
					if (dmem.rvalid)
						state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// ********************************************************
	// Writeback
	// ********************************************************
	assign wb_en = em.valid && (em.wb_sel != WB_NONE) && (em.rd != '0) && !m_busy;
	assign wb_rd = em.rd;

	always_comb begin
		case (em.wb_sel)
			WB_MEM:  wb_data = dmem.rdata;
			WB_PC4:  wb_data = em.pc4;
			default: wb_data = em.alu_result;
		endcase
	end

	assign m_valid = em.valid;
	assign m_rd    = em.rd;

	a_no_stray_rvalid: assert property (@(posedge clk) disable iff (!arst_n)
		state_q == IDLE |-> !dmem.rvalid);

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
	import rv_core_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       stall_m,
	input  de_bundle_t de,
	output em_bundle_t em,
	output logic       redirect,
	output addr_t      redirect_pc,
	output logic       e_valid,
	output reg_idx_t   e_rd
);

	word_t alu_res;
	logic  taken;

	// ********************************************************
	// ALU and branch compare
	// ********************************************************
	always_comb begin
		case (de.alu_op)
			ALU_ADD:    alu_res = de.op1 + de.op2;
			ALU_SUB:    alu_res = de.op1 - de.op2;
			ALU_AND:    alu_res = de.op1 & de.op2;
			ALU_OR:     alu_res = de.op1 | de.op2;
			ALU_XOR:    alu_res = de.op1 ^ de.op2;
			ALU_SLT:    alu_res = {31'b0, ($signed(de.op1) < $signed(de.op2))};
			ALU_PASS_B: alu_res = de.op2;
			default:    alu_res = de.op1 + de.op2;
		endcase
	end

	// Branches compare rs1 against rs2 carried in op2
	always_comb begin
		case (de.ctrl_kind)
			CTRL_BEQ: taken = (de.op1 == de.op2);
			CTRL_BNE: taken = (de.op1 != de.op2);
			CTRL_JAL: taken = 1'b1;
			default:  taken = 1'b0;
		endcase
	end

	// Held back while memory is busy so it fires exactly once
	assign redirect    = de.valid && taken && !stall_m;
	assign redirect_pc = de.pc + addr_t'(de.imm);

	assign e_valid = de.valid;
	assign e_rd    = de.rd;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			em <= '0;
		end else if (!stall_m) begin
			em.alu_result <= alu_res;
			em.store_data <= de.rs2_data;
			em.pc4        <= word_t'(de.pc + addr_t'(4));
			em.rd         <= de.rd;
			em.wb_sel     <= de.wb_sel;
			em.mem_read   <= de.mem_read;
			em.mem_write  <= de.mem_write;
			em.valid      <= de.valid;
		end
	end

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`include "rv_core_config.svh"

module decode_stage
	import rv_core_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       stall_d,
	input  logic       flush_fd,
	input  logic       bubble_e,
	input  fd_bundle_t fd,
	input  logic       wb_en,
	input  reg_idx_t   wb_rd,
	input  word_t      wb_data,
	output de_bundle_t de,
	output logic       d_valid,
	output reg_idx_t   d_rs1,
	output reg_idx_t   d_rs2,
	output logic       d_uses_rs2
);

	word_t      rf_q [`RV_NUM_REGS];
	reg_idx_t   rs1;
	reg_idx_t   rs2;
	logic [2:0] funct3;
	word_t      rs1_data;
	word_t      rs2_data;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_j;
	word_t      imm_u;
	logic       known;
	logic       uses_rs1;
	logic       uses_rs2;
	de_bundle_t dec;

	assign rs1    = fd.instr[19:15];
	assign rs2    = fd.instr[24:20];
	assign funct3 = fd.instr[14:12];

	assign imm_i = {{20{fd.instr[31]}}, fd.instr[31:20]};
	assign imm_s = {{20{fd.instr[31]}}, fd.instr[31:25], fd.instr[11:7]};
	assign imm_b = {{19{fd.instr[31]}}, fd.instr[31], fd.instr[7],
		fd.instr[30:25], fd.instr[11:8], 1'b0};
	assign imm_j = {{11{fd.instr[31]}}, fd.instr[31], fd.instr[19:12],
		fd.instr[20], fd.instr[30:21], 1'b0};
	assign imm_u = {fd.instr[31:12], 12'h000};

	assign rs1_data = (rs1 == '0) ? '0 : rf_q[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : rf_q[rs2];

	// ********************************************************
	// Decoder
	// ********************************************************
	always_comb begin
		dec           = '0;
		dec.pc        = fd.pc;
		dec.op1       = rs1_data;
		dec.op2       = rs2_data;
		dec.rs2_data  = rs2_data;
		dec.imm       = imm_i;
		dec.rd        = fd.instr[11:7];
		dec.alu_op    = ALU_ADD;
		dec.wb_sel    = WB_NONE;
		dec.ctrl_kind = CTRL_NONE;
		known    = 1'b1;
		uses_rs1 = 1'b1;
		uses_rs2 = 1'b0;
		case (fd.instr[6:0])
			OP_R: begin
				uses_rs2   = 1'b1;
				dec.wb_sel = WB_ALU;
				case (funct3)
					3'b000: dec.alu_op = fd.instr[30] ? ALU_SUB : ALU_ADD;
					3'b010: dec.alu_op = ALU_SLT;
					3'b100: dec.alu_op = ALU_XOR;
					3'b110: dec.alu_op = ALU_OR;
					3'b111: dec.alu_op = ALU_AND;
					default: known = 1'b0;
				endcase
			end
			OP_I: begin
				dec.op2    = imm_i;
				dec.wb_sel = WB_ALU;
				case (funct3)
					3'b000: dec.alu_op = ALU_ADD;
					3'b100: dec.alu_op = ALU_XOR;
					3'b110: dec.alu_op = ALU_OR;
					3'b111: dec.alu_op = ALU_AND;
					default: known = 1'b0;
				endcase
			end
			OP_LUI: begin
				uses_rs1   = 1'b0;
				dec.op2    = imm_u;
				dec.alu_op = ALU_PASS_B;
				dec.wb_sel = WB_ALU;
			end
			OP_LOAD: begin
				dec.op2      = imm_i;
				dec.mem_read = 1'b1;
				dec.wb_sel   = WB_MEM;
				known        = (funct3 == 3'b010);
			end
			OP_STORE: begin
				uses_rs2      = 1'b1;
				dec.op2       = imm_s;
				dec.imm       = imm_s;
				dec.mem_write = 1'b1;
				known         = (funct3 == 3'b010);
			end
			OP_BRANCH: begin
				uses_rs2 = 1'b1;
				dec.imm  = imm_b;
				case (funct3)
					3'b000: dec.ctrl_kind = CTRL_BEQ;
					3'b001: dec.ctrl_kind = CTRL_BNE;
					default: known = 1'b0;
				endcase
			end
			OP_JAL: begin
				uses_rs1      = 1'b0;
				dec.imm       = imm_j;
				dec.wb_sel    = WB_PC4;
				dec.ctrl_kind = CTRL_JAL;
			end
			default: known = 1'b0;
		endcase
		// Unsupported encodings leave as a bubble
		dec.valid = fd.valid && known;
		if (dec.wb_sel == WB_NONE)
			dec.rd = '0;
	end

	assign d_valid    = dec.valid;
	assign d_rs1      = uses_rs1 ? rs1 : '0;
	assign d_rs2      = uses_rs2 ? rs2 : '0;
	assign d_uses_rs2 = uses_rs2;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			de <= '0;
		end else if (!stall_d) begin
			de <= dec;
			if (flush_fd || bubble_e)
				de.valid <= 1'b0;
		end
	end

	// Register file, written at the end of the memory stage
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `RV_NUM_REGS; i++)
				rf_q[i] <= '0;
		end else if (wb_en && wb_rd != '0) begin
			rf_q[wb_rd] <= wb_data;
		end
	end

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/1ps
`include "rv_core_config.svh"

module fetch_stage
	import rv_core_pkg::*;
(
	input  logic          clk,
	input  logic          arst_n,
	input  logic          stall_f,
	input  logic          flush_fd,
	input  logic          redirect,
	input  addr_t         redirect_pc,
	mem_port_if.requester imem,
	output fd_bundle_t    fd
);

	typedef enum logic [1:0] {IDLE, WAIT, HOLD} fetch_state_e;
	typedef logic [`RV_IADDR_W-1:0] iaddr_t;

	fetch_state_e state_q;
	iaddr_t       pc_q;
	iaddr_t       addr_q;
	logic         req_q;
	logic         drop_q;
	fd_bundle_t   hold_q;
	fd_bundle_t   resp;

	assign resp = '{pc: addr_t'(addr_q), instr: imem.rdata, valid: 1'b1};

	assign imem.req   = req_q;
	assign imem.addr  = addr_t'(addr_q);
	assign imem.write = 1'b0;
	assign imem.wdata = '0;
	assign imem.wmask = '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= IDLE;
			pc_q    <= iaddr_t'(`RV_RESET_PC);
			addr_q  <= '0;
			req_q   <= 1'b0;
			drop_q  <= 1'b0;
			fd      <= '0;
		end else begin
			if (req_q && imem.ready)
				req_q <= 1'b0;

			// Decode took the slot or it is flushed
			if (!stall_f || flush_fd)
				fd.valid <= 1'b0;

			if (redirect) begin
				pc_q <= iaddr_t'(redirect_pc);
				case (state_q)
					WAIT: begin
						if (imem.rvalid) begin
							state_q <= IDLE;
							drop_q  <= 1'b0;
						end else begin
							// Response still in flight gets thrown away
							drop_q <= 1'b1;
						end
					end
					default: state_q <= IDLE;
				endcase
			end else begin
				case (state_q)
					IDLE: begin
						req_q   <= 1'b1;
						addr_q  <= pc_q;
						pc_q    <= pc_q + iaddr_t'(4);
						state_q <= WAIT;
					end
					WAIT: begin
						if (imem.rvalid) begin
							if (drop_q) begin
								drop_q  <= 1'b0;
								state_q <= IDLE;
							end else if (!stall_f) begin
								fd      <= resp;
								state_q <= IDLE;
							end else begin
								state_q <= HOLD;
							end
						end
					end
					HOLD: begin
						if (!stall_f) begin
							fd      <= hold_q;
							state_q <= IDLE;
						end
					end
					default: state_q <= IDLE;
				endcase
			end
		end
	end

	// Only read back from HOLD
	always_ff @(posedge clk) begin
		if (imem.rvalid)
			hold_q <= resp;
	end

	a_addr_hold: assert property (@(posedge clk) disable iff (!arst_n)
		imem.req && !imem.ready |=> imem.req && $stable(imem.addr));

endmodule

//--- hw/core_ctrl.sv
`timescale 1ns/1ps

module core_ctrl
	import rv_core_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     d_valid,
	input  reg_idx_t d_rs1,
	input  reg_idx_t d_rs2,
	input  logic     d_uses_rs2,
	input  logic     e_valid,
	input  reg_idx_t e_rd,
	input  logic     m_valid,
	input  reg_idx_t m_rd,
	input  logic     m_busy,
	input  logic     redirect,
	output logic     stall_f,
	output logic     stall_d,
	output logic     bubble_e,
	output logic     flush_fd,
	output logic     stall_m
);

	logic hit_rs1;
	logic hit_rs2;
	logic hazard;

	// Scoreboard of destinations still in execute or memory
	// Non-writing instructions carry rd 0 and x0 never blocks
	assign hit_rs1 = (d_rs1 != '0) &&
		((e_valid && e_rd == d_rs1) || (m_valid && m_rd == d_rs1));
	assign hit_rs2 = d_uses_rs2 && (d_rs2 != '0) &&
		((e_valid && e_rd == d_rs2) || (m_valid && m_rd == d_rs2));

	assign hazard = d_valid && (hit_rs1 || hit_rs2);

	// Pending data access freezes the whole pipe
	assign stall_m = m_busy;
	assign stall_d = m_busy;

	// Redirect beats the interlock since the decode slot gets squashed
	assign flush_fd = redirect && !m_busy;
	assign stall_f  = m_busy || (hazard && !redirect);
	assign bubble_e = hazard && !redirect && !m_busy;

	// Squashed slot reaches execute empty
	a_squash_empty: assert property (@(posedge clk) disable iff (!arst_n)
		(bubble_e || flush_fd) |=> !e_valid);

	// Empty execute slot reaches memory empty and never writes back
	a_empty_moves_on: assert property (@(posedge clk) disable iff (!arst_n)
		(!e_valid && !m_busy) |=> !m_valid);

endmodule

//--- hw/mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if
	import rv_core_pkg::*;
();
	logic   req;
	addr_t  addr;
	logic   write;
	word_t  wdata;
	wmask_t wmask;
	logic   ready;
	word_t  rdata;
	logic   rvalid;

	modport requester (
		output req, addr, write, wdata, wmask,
		input  ready, rdata, rvalid
	);

	modport responder (
		input  req, addr, write, wdata, wmask,
		output ready, rdata, rvalid
	);

endinterface

//--- hw/rv_core_pkg.sv
`include "rv_core_config.svh"

package rv_core_pkg;

	typedef logic [31:0]             word_t;
	typedef logic [`RV_DADDR_W-1:0] addr_t;
	typedef logic [4:0]              reg_idx_t;
	typedef logic [3:0]              wmask_t;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP_R      = 7'b0110011,
		OP_I      = 7'b0010011,
		OP_LUI    = 7'b0110111,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

	typedef enum logic [1:0] {CTRL_NONE, CTRL_BEQ, CTRL_BNE, CTRL_JAL} ctrl_kind_e;

	// ********************************************************
	// Stage bundles
	// ********************************************************
	typedef struct packed {
		addr_t pc;
		word_t instr;
		logic  valid;
	} fd_bundle_t;

	typedef struct packed {
		addr_t      pc;
		word_t      op1;
		word_t      op2;
		word_t      rs2_data;
		word_t      imm;
		alu_op_e    alu_op;
		wb_sel_e    wb_sel;
		reg_idx_t   rd;
		logic       mem_read;
		logic       mem_write;
		ctrl_kind_e ctrl_kind;
		logic       valid;
	} de_bundle_t;

	typedef struct packed {
		word_t    alu_result;
		word_t    store_data;
		word_t    pc4;
		reg_idx_t rd;
		wb_sel_e  wb_sel;
		logic     mem_read;
		logic     mem_write;
		logic     valid;
	} em_bundle_t;

endpackage

//--- hw/rv_core_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// Architectural register count, x0 included
`define RV_NUM_REGS 32

// Address widths of the instruction and data ports
`define RV_IADDR_W 32
`define RV_DADDR_W 32

`endif
